//--- verilog/predictor_config.svh
`ifndef PREDICTOR_CONFIG_SVH
`define PREDICTOR_CONFIG_SVH

// Pattern table of 2**PRED_INDEX_BITS counters
`define PRED_INDEX_BITS            4
// Global history length in resolved branches
`define PRED_HISTORY_BITS          4

// Counter runs from 0 to RANGE-1 and starts weakly not taken
`define PRED_COUNTER_RANGE         4
`define PRED_COUNTER_RESET         1

// Random byte per request, steps into the end values need random < threshold
`define PRED_RANDOM_BITS           8
`define PRED_SATURATION_THRESHOLD  64

`define PRED_PC_BITS               32

// Queue depth equals the client's initial credits
`define PRED_REQUEST_CREDITS       4
`define PRED_RESPONSE_CREDITS      2

`endif

//--- verilog/predictor_pkg.sv
`include "predictor_config.svh"

package predictor_pkg;

  // Request kinds on the client interface
  typedef enum logic {
    LOOKUP  = 1'b0,
    RESOLVE = 1'b1
  } request_kind_t;

  // Raw pattern counter value, upper bit is the prediction
  typedef logic [$clog2(`PRED_COUNTER_RANGE)-1:0] count_t;

  // Pattern table index
  typedef logic [`PRED_INDEX_BITS-1:0] table_index_t;

endpackage

//--- verilog/probabilistic_saturating_counter.sv
`timescale 1ns/1ps

module probabilistic_saturating_counter #(
  parameter int RANGE       = 4,
  parameter int RESET_VALUE = 0,
  parameter int RANDOM_BITS = 8,
  parameter int THRESHOLD   = 64
) (
  input  logic                       clock,
  input  logic                       resetn,
  input  logic                       increment,
  input  logic                       decrement,
  input  logic [RANDOM_BITS-1:0]     random_number,
  output logic [$clog2(RANGE)-1:0]   count
);

  localparam int COUNT_BITS = $clog2(RANGE);
  localparam logic [COUNT_BITS-1:0] COUNT_MAX = COUNT_BITS'(RANGE - 1);

  logic at_min;
  logic at_max;
  logic below_max;
  logic above_min;
  logic saturate_ok;

  assign at_min    = count == '0;
  assign at_max    = count == COUNT_MAX;
  // One step away from an end value
  assign below_max = count == COUNT_MAX - 1'b1;
  assign above_min = count == COUNT_BITS'(1);

  // Random gate for steps into the end values
  assign saturate_ok = random_number < THRESHOLD;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      count <= COUNT_BITS'(RESET_VALUE);
    end else if (increment) begin
      // Increment wins over a simultaneous decrement
      if (!at_max && (!below_max || saturate_ok)) begin
        count <= count + 1'b1;
      end
    end else if (decrement) begin
      if (!at_min && (!above_min || saturate_ok)) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- verilog/request_queue.sv
`timescale 1ns/1ps
`include "predictor_config.svh"

module request_queue (
  input  logic                              clock,
  input  logic                              resetn,
  input  logic                              in_valid,
  input  predictor_pkg::request_kind_t      in_kind,
  input  logic [`PRED_PC_BITS-1:0]          in_pc,
  input  logic                              in_taken,
  input  logic [`PRED_RANDOM_BITS-1:0]      in_random,
  output logic                              credit,
  output logic                              out_valid,
  output predictor_pkg::request_kind_t      out_kind,
  output logic [`PRED_PC_BITS-1:0]          out_pc,
  output logic                              out_taken,
  output logic [`PRED_RANDOM_BITS-1:0]      out_random,
  input  logic                              out_ready
);

  localparam int DEPTH      = `PRED_REQUEST_CREDITS;
  localparam int PTR_BITS   = $clog2(DEPTH);
  localparam int COUNT_BITS = $clog2(DEPTH + 1);

  // Entry storage
  predictor_pkg::request_kind_t      kind_mem   [DEPTH];
  logic [`PRED_PC_BITS-1:0]          pc_mem     [DEPTH];
  logic                              taken_mem  [DEPTH];
  logic [`PRED_RANDOM_BITS-1:0]      random_mem [DEPTH];

  logic [PTR_BITS-1:0]   wr_ptr;
  logic [PTR_BITS-1:0]   rd_ptr;
  logic [COUNT_BITS-1:0] fill;
  logic                  pop;

  // Client credits guarantee room, so every valid request is written
  assign out_valid = fill != '0;
  assign pop       = out_valid && out_ready;

  // Head entry straight from storage
  assign out_kind   = kind_mem[rd_ptr];
  assign out_pc     = pc_mem[rd_ptr];
  assign out_taken  = taken_mem[rd_ptr];
  assign out_random = random_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (in_valid) begin
      kind_mem[wr_ptr]   <= in_kind;
      pc_mem[wr_ptr]     <= in_pc;
      taken_mem[wr_ptr]  <= in_taken;
      random_mem[wr_ptr] <= in_random;
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      credit <= 1'b0;
    end else begin
      // Pointers wrap at the last entry
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill   <= fill + COUNT_BITS'(in_valid) - COUNT_BITS'(pop);
      // One credit back to the client per released entry
      credit <= pop;
    end
  end

endmodule

//--- verilog/history_index_stage.sv
`timescale 1ns/1ps
`include "predictor_config.svh"

module history_index_stage (
  input  logic                              clock,
  input  logic                              resetn,
  input  logic                              in_valid,
  input  predictor_pkg::request_kind_t      in_kind,
  input  logic [`PRED_PC_BITS-1:0]          in_pc,
  input  logic                              in_taken,
  input  logic [`PRED_RANDOM_BITS-1:0]      in_random,
  output logic                              in_ready,
  output logic                              out_valid,
  output predictor_pkg::request_kind_t      out_kind,
  output predictor_pkg::table_index_t       out_index,
  output logic                              out_taken,
  output logic [`PRED_RANDOM_BITS-1:0]      out_random,
  input  logic                              out_ready
);

  logic [`PRED_HISTORY_BITS-1:0] history;
  predictor_pkg::table_index_t   index;
  logic                          transfer;

  // Stage register frees up when empty or when its item moves on
  assign in_ready = !out_valid || out_ready;
  assign transfer = in_valid && in_ready;

  // Word-aligned address bits folded with the global history
  assign index = in_pc[`PRED_INDEX_BITS+1:2] ^ predictor_pkg::table_index_t'(history);

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      out_valid <= 1'b0;
      history   <= '0;
    end else begin
      if (in_ready) begin
        out_valid <= in_valid;
      end
      // Resolves update history in request order
      if (transfer && in_kind == predictor_pkg::RESOLVE) begin
        history <= {history[`PRED_HISTORY_BITS-2:0], in_taken};
      end
    end
  end

  // Index travels on, the address stops here
  always_ff @(posedge clock) begin
    if (transfer) begin
      out_kind   <= in_kind;
      out_index  <= index;
      out_taken  <= in_taken;
      out_random <= in_random;
    end
  end

endmodule

//--- verilog/counter_table_stage.sv
`timescale 1ns/1ps
`include "predictor_config.svh"

module counter_table_stage (
  input  logic                              clock,
  input  logic                              resetn,
  input  logic                              in_valid,
  input  predictor_pkg::request_kind_t      in_kind,
  input  predictor_pkg::table_index_t       in_index,
  input  logic                              in_taken,
  input  logic [`PRED_RANDOM_BITS-1:0]      in_random,
  output logic                              in_ready,
  output logic                              out_valid,
  output predictor_pkg::count_t             out_count,
  input  logic                              out_ready
);

  localparam int TABLE_SIZE = 1 << `PRED_INDEX_BITS;

  predictor_pkg::count_t counts    [TABLE_SIZE];
  logic [TABLE_SIZE-1:0] increment;
  logic [TABLE_SIZE-1:0] decrement;
  logic                  transfer;
  logic                  train;
  logic                  lookup;

  assign in_ready = !out_valid || out_ready;
  assign transfer = in_valid && in_ready;
  assign train    = transfer && in_kind == predictor_pkg::RESOLVE;
  assign lookup   = in_valid && in_kind == predictor_pkg::LOOKUP;

  // Pattern counters, all gated by the same request's random byte
  for (genvar i = 0; i < TABLE_SIZE; i++) begin : g_counter
    // Decode the resolve index to one counter
    assign increment[i] = train && in_taken && in_index == predictor_pkg::table_index_t'(i);
    assign decrement[i] = train && !in_taken && in_index == predictor_pkg::table_index_t'(i);

    probabilistic_saturating_counter #(
      .RANGE       (`PRED_COUNTER_RANGE),
      .RESET_VALUE (`PRED_COUNTER_RESET),
      .RANDOM_BITS (`PRED_RANDOM_BITS),
      .THRESHOLD   (`PRED_SATURATION_THRESHOLD)
    ) u_counter (
      .clock         (clock),
      .resetn        (resetn),
      .increment     (increment[i]),
      .decrement     (decrement[i]),
      .random_number (in_random),
      .count         (counts[i])
    );
  end

  // Only lookups become output items, resolves end here
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= lookup;
    end
  end

  // Read sees every resolve trained at earlier edges
  always_ff @(posedge clock) begin
    if (transfer && lookup) begin
      out_count <= counts[in_index];
    end
  end

endmodule

//--- verilog/response_issue_stage.sv
`timescale 1ns/1ps
`include "predictor_config.svh"

module response_issue_stage (
  input  logic                    clock,
  input  logic                    resetn,
  input  logic                    in_valid,
  input  predictor_pkg::count_t   in_count,
  output logic                    in_ready,
  output logic                    resp_valid,
  output logic                    resp_taken,
  output predictor_pkg::count_t   resp_count,
  input  logic                    resp_credit
);

  localparam int CREDIT_BITS = $clog2(`PRED_RESPONSE_CREDITS + 1);

  logic [CREDIT_BITS-1:0] credits;
  logic                   issue;

  // Without a credit the lookup waits upstream and the pipe stalls
  assign in_ready = credits != '0;
  assign issue    = in_valid && in_ready;

  // Prediction is the counter's upper half
  assign resp_taken = resp_count[$bits(predictor_pkg::count_t)-1];

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      resp_valid <= 1'b0;
      credits    <= CREDIT_BITS'(`PRED_RESPONSE_CREDITS);
    end else begin
      // One cycle pulse per response
      resp_valid <= issue;
      // Return and spend may land in the same cycle
      credits    <= credits + CREDIT_BITS'(resp_credit) - CREDIT_BITS'(issue);
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      resp_count <= in_count;
    end
  end

endmodule

//--- verilog/branch_predictor_top.sv
`timescale 1ns/1ps
`include "predictor_config.svh"

module branch_predictor_top (
  input  logic                              clock,
  input  logic                              resetn,
  // Client requests
  input  logic                              req_valid,
  input  predictor_pkg::request_kind_t      req_kind,
  input  logic [`PRED_PC_BITS-1:0]          req_pc,
  input  logic                              req_taken,
  input  logic [`PRED_RANDOM_BITS-1:0]      req_random,
  output logic                              req_credit,
  // Lookup responses
  output logic                              resp_valid,
  output logic                              resp_taken,
  output predictor_pkg::count_t             resp_count,
  input  logic                              resp_credit
);

  // Queue to history
  logic                              queue_valid;
  logic                              queue_ready;
  predictor_pkg::request_kind_t      queue_kind;
  logic [`PRED_PC_BITS-1:0]          queue_pc;
  logic                              queue_taken;
  logic [`PRED_RANDOM_BITS-1:0]      queue_random;

  // History to table
  logic                              hist_valid;
  logic                              hist_ready;
  predictor_pkg::request_kind_t      hist_kind;
  predictor_pkg::table_index_t       hist_index;
  logic                              hist_taken;
  logic [`PRED_RANDOM_BITS-1:0]      hist_random;

  // Table to response
  logic                              table_valid;
  logic                              table_ready;
  predictor_pkg::count_t             table_count;

  request_queue u_request_queue (
    .clock      (clock),
    .resetn     (resetn),
    .in_valid   (req_valid),
    .in_kind    (req_kind),
    .in_pc      (req_pc),
    .in_taken   (req_taken),
    .in_random  (req_random),
    .credit     (req_credit),
    .out_valid  (queue_valid),
    .out_kind   (queue_kind),
    .out_pc     (queue_pc),
    .out_taken  (queue_taken),
    .out_random (queue_random),
    .out_ready  (queue_ready)
  );

  history_index_stage u_history_index_stage (
    .clock      (clock),
    .resetn     (resetn),
    .in_valid   (queue_valid),
    .in_kind    (queue_kind),
    .in_pc      (queue_pc),
    .in_taken   (queue_taken),
    .in_random  (queue_random),
    .in_ready   (queue_ready),
    .out_valid  (hist_valid),
    .out_kind   (hist_kind),
    .out_index  (hist_index),
    .out_taken  (hist_taken),
    .out_random (hist_random),
    .out_ready  (hist_ready)
  );

  counter_table_stage u_counter_table_stage (
    .clock     (clock),
    .resetn    (resetn),
    .in_valid  (hist_valid),
    .in_kind   (hist_kind),
    .in_index  (hist_index),
    .in_taken  (hist_taken),
    .in_random (hist_random),
    .in_ready  (hist_ready),
    .out_valid (table_valid),
    .out_count (table_count),
    .out_ready (table_ready)
  );

  response_issue_stage u_response_issue_stage (
    .clock       (clock),
    .resetn      (resetn),
    .in_valid    (table_valid),
    .in_count    (table_count),
    .in_ready    (table_ready),
    .resp_valid  (resp_valid),
    .resp_taken  (resp_taken),
    .resp_count  (resp_count),
    .resp_credit (resp_credit)
  );

endmodule

//--- testbench/branch_predictor_tb.sv
`timescale 1ns/1ps
`include "predictor_config.svh"

module branch_predictor_tb;

  localparam int REQ_CREDITS = `PRED_REQUEST_CREDITS;

  logic                              clock = 1'b0;
  logic                              resetn;
  logic                              req_valid;
  predictor_pkg::request_kind_t      req_kind;
  logic [`PRED_PC_BITS-1:0]          req_pc;
  logic                              req_taken;
  logic [`PRED_RANDOM_BITS-1:0]      req_random;
  logic                              req_credit;
  logic                              resp_valid;
  logic                              resp_taken;
  predictor_pkg::count_t             resp_count;
  logic                              resp_credit;

  // Requests in file order
  predictor_pkg::request_kind_t  kind_q   [$];
  logic [`PRED_PC_BITS-1:0]      pc_q     [$];
  logic                          taken_q  [$];
  logic [`PRED_RANDOM_BITS-1:0]  random_q [$];
  // Expected lookup results, oldest first
  logic                          exp_taken_q [$];
  predictor_pkg::count_t         exp_count_q [$];
  int                            exp_line_q  [$];

  int          client_credits   = REQ_CREDITS;
  int          credit_pulses    = 0;
  int          responses_seen   = 0;
  int          credits_returned = 0;
  int          gap_left         = 0;
  logic [31:0] lfsr             = 32'hd8651794;

  branch_predictor_top u_dut (
    .clock       (clock),
    .resetn      (resetn),
    .req_valid   (req_valid),
    .req_kind    (req_kind),
    .req_pc      (req_pc),
    .req_taken   (req_taken),
    .req_random  (req_random),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp_taken  (resp_taken),
    .resp_count  (resp_count),
    .resp_credit (resp_credit)
  );

  // 20 ns period
  always #10 clock = ~clock;

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    $display("TESTS FAILED");
    $fatal(1, "Value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "Run aborted");
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic int take_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      value = (value << 1) | int'(lfsr[0]);
    end
    return value;
  endfunction

  // Client side credit count, spent per valid cycle and refilled per pulse
  always @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      client_credits <= REQ_CREDITS;
      credit_pulses  <= 0;
    end else begin
      client_credits <= client_credits + int'(req_credit) - int'(req_valid);
      if (req_credit) begin
        credit_pulses <= credit_pulses + 1;
      end
    end
  end

  // Compare each response with the oldest outstanding lookup
  always @(posedge clock) begin
    if (resetn && resp_valid) begin
      assert (exp_count_q.size() != 0)
        else report_failure("A response arrived with no lookup outstanding");
      if (exp_count_q.size() != 0) begin
        assert (resp_count == exp_count_q[0])
          else report_mismatch($sformatf("lookup line %0d count", exp_line_q[0]),
                               int'(exp_count_q[0]), int'(resp_count));
        assert (resp_taken == exp_taken_q[0])
          else report_mismatch($sformatf("lookup line %0d prediction", exp_line_q[0]),
                               int'(exp_taken_q[0]), int'(resp_taken));
        void'(exp_count_q.pop_front());
        void'(exp_taken_q.pop_front());
        void'(exp_line_q.pop_front());
        responses_seen <= responses_seen + 1;
      end
    end
  end

  // Consumer hands back one credit per response after a random gap of 0 to 30 cycles
  always @(posedge clock) begin
    resp_credit <= 1'b0;
    if (gap_left != 0) begin
      gap_left <= gap_left - 1;
    end else if (resetn && credits_returned < responses_seen) begin
      resp_credit      <= 1'b1;
      credits_returned <= credits_returned + 1;
      gap_left         <= take_bits(4) * 2;
    end
  end

  initial begin
    int               fd;
    int               status;
    int               line;
    int               sent;
    int               avail;
    int               total;
    int               lookups;
    logic [8*120-1:0] header;
    logic [3:0]       kind_f;
    logic [31:0]      pc_f;
    logic [3:0]       taken_f;
    logic [7:0]       random_f;
    logic [3:0]       exp_taken_f;
    logic [3:0]       exp_count_f;

    resetn      = 1'b0;
    req_valid   = 1'b0;
    req_kind    = predictor_pkg::LOOKUP;
    req_pc      = '0;
    req_taken   = 1'b0;
    req_random  = '0;
    resp_credit = 1'b0;

    // Two header lines, then one request per line
    fd = $fopen("testbench/predictor_stimulus.txt", "r");
    assert (fd != 0) else report_failure("Cannot open testbench/predictor_stimulus.txt");
    status = $fgets(header, fd);
    status = $fgets(header, fd);
    line   = 3;
    status = $fscanf(fd, "%h %h %h %h %h %h",
                     kind_f, pc_f, taken_f, random_f, exp_taken_f, exp_count_f);
    while (status == 6) begin
      kind_q.push_back(predictor_pkg::request_kind_t'(kind_f[0]));
      pc_q.push_back(pc_f);
      taken_q.push_back(taken_f[0]);
      random_q.push_back(random_f);
      if (kind_f == 4'h0) begin
        exp_taken_q.push_back(exp_taken_f[0]);
        exp_count_q.push_back(predictor_pkg::count_t'(exp_count_f));
        exp_line_q.push_back(line);
      end
      line++;
      status = $fscanf(fd, "%h %h %h %h %h %h",
                       kind_f, pc_f, taken_f, random_f, exp_taken_f, exp_count_f);
    end
    $fclose(fd);
    total   = kind_q.size();
    lookups = exp_count_q.size();
    assert (total != 0) else report_failure("The stimulus file holds no requests");

    // Budget of 50 cycles per request plus slack for reset and drain
    fork
      begin
        repeat (50 * total + 200) @(posedge clock);
        report_failure("Timeout, the predictor stopped producing responses or credits");
      end
    join_none

    repeat (10) @(posedge clock);
    resetn <= 1'b1;

    // Send back to back while a credit remains after this edge
    sent = 0;
    while (sent < total) begin
      @(posedge clock);
      avail = client_credits + int'(req_credit) - int'(req_valid);
      assert (avail <= REQ_CREDITS)
        else report_failure("The predictor returned more request credits than requests sent");
      if (avail > 0) begin
        req_valid  <= 1'b1;
        req_kind   <= kind_q[sent];
        req_pc     <= pc_q[sent];
        req_taken  <= taken_q[sent];
        req_random <= random_q[sent];
        sent++;
      end else begin
        req_valid <= 1'b0;
      end
    end
    @(posedge clock);
    req_valid <= 1'b0;

    wait (responses_seen == lookups && credit_pulses == total);
    // Idle window to catch stray responses or credit pulses
    repeat (20) @(posedge clock);
    assert (credit_pulses == total)
      else report_mismatch("request credit total", total, credit_pulses);
    assert (client_credits == REQ_CREDITS)
      else report_mismatch("client credits after drain", REQ_CREDITS, client_credits);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- testbench/predictor_stimulus.txt
# kind (0 lookup, 1 resolve), pc, taken, random, expected taken, expected count, all hex
# Expected columns apply to lookups only, resolves carry 0 0
0 00001000 0 5a 0 1
1 0000100c 1 c8 0 0
0 00001008 0 11 1 2
1 00001008 1 9a 0 0
0 00001000 0 22 1 2
1 00001000 1 40 0 0
0 00001010 0 33 1 2
1 00001010 1 3f 0 0
0 00001030 0 44 1 3
1 00001030 1 05 0 0
1 00001030 0 ff 0 0
0 00001034 0 55 1 2
1 00001034 0 10 0 0
0 0000103c 0 66 0 1
1 0000103c 0 80 0 0
0 0000102c 0 77 0 1
1 0000102c 0 00 0 0
0 0000100c 0 88 0 0
1 0000100c 0 20 0 0
1 00002014 1 77 0 0
1 00002014 1 01 0 0
0 00002018 0 99 1 2
1 00002030 0 e0 0 0
0 00002018 0 aa 0 1
0 0000200c 0 bb 1 2
0 00003008 0 cc 1 2
0 00003014 0 dd 0 0
0 0000303c 0 ee 0 1
0 deadbeef 0 ff 0 1

//--- flist.f
+incdir+verilog
verilog/predictor_pkg.sv
verilog/probabilistic_saturating_counter.sv
verilog/request_queue.sv
verilog/history_index_stage.sv
verilog/counter_table_stage.sv
verilog/response_issue_stage.sv
verilog/branch_predictor_top.sv
testbench/branch_predictor_tb.sv

//--- Makefile
# Verilator build and run for the branch predictor testbench
VERILATOR       ?= verilator
TOP             ?= branch_predictor_tb
FLIST           ?= flist.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
SOURCES         := $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
BINARY          := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Simulator exit status is the test result
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)
